//--- src/disk_pkg.sv
`default_nettype none

package disk_pkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] gaddr_t;
	typedef logic [31:0] lba_t;
	typedef logic [7:0]  baddr_t;
	typedef logic [7:0]  err_code_t;

	// Guest bus cycle as seen at the register decode
	typedef struct packed {
		gaddr_t addr;
		word_t  din;
		logic   sync;
		logic   we;
		logic   stb;
	} bus_cycle_t;

	typedef struct packed {
		gaddr_t addr;
		word_t  wdata;
		logic   we;
	} mem_req_t;

	typedef enum logic [1:0] {
		XF_RD_WORD,
		XF_WR_WORD,
		XF_SECT_TO_MEM,
		XF_MEM_TO_SECT
	} xfer_kind_t;

	typedef struct packed {
		xfer_kind_t kind;
		gaddr_t     addr;
		word_t      wdata;
		logic [8:0] count;
	} xfer_cmd_t;

	// Bit 0 of rd and wr is the unused hard-disk slot
	typedef struct packed {
		lba_t       lba;
		logic [2:0] rd;
		logic [2:0] wr;
	} sd_req_t;

	typedef struct packed {
		lba_t size;
		logic readonly;
	} img_info_t;

	localparam err_code_t ERR_OK       = 8'd0;
	localparam err_code_t ERR_READONLY = 8'd1;
	localparam err_code_t ERR_RANGE    = 8'd5;
	localparam err_code_t ERR_BAD_DISK = 8'd6;
	localparam err_code_t ERR_BAD_ARG  = 8'd10;

	localparam gaddr_t REG_LBA  = 16'o177132;
	localparam gaddr_t ERR_ADDR = 16'o52;

	localparam int SECTOR_WORDS = 256;
	localparam int NUM_SLOTS    = 2;

endpackage

`default_nettype wire

//--- src/sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sector_buffer import disk_pkg::*; (
	input  logic   clk_sys,

	input  baddr_t waddr,
	input  word_t  wdata,
	input  logic   we,

	input  baddr_t raddr,
	output word_t  q
);

	word_t ram [SECTOR_WORDS];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			ram[waddr] <= wdata;
		end
		q <= ram[raddr];
	end

endmodule

`default_nettype wire

//--- src/bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bus_regs import disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  bus_cycle_t bus,
	output logic       bus_ack,

	output logic       start_valid,
	input  logic       start_ready,
	output gaddr_t     sp
);

	logic sel;
	logic stb_q;
	logic stb_rise;

	// Word-aligned match on write cycles
	assign sel      = bus.sync && bus.we && (bus.addr[15:1] == REG_LBA[15:1]);
	assign bus_ack  = bus.stb && sel;
	assign stb_rise = bus.stb && !stb_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= bus.stb;
		end
	end

	// A strobe while the controller is busy is acked but not queued
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			start_valid <= 1'b0;
		end else if (start_valid && start_ready) begin
			start_valid <= 1'b0;
		end else if (stb_rise && sel && start_ready) begin
			start_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (stb_rise && sel && start_ready && !start_valid) begin
			sp <= bus.din;
		end
	end

endmodule

`default_nettype wire

//--- src/xfer_engine.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_engine import disk_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,

	input  logic      cmd_valid,
	output logic      cmd_ready,
	input  xfer_cmd_t cmd,
	output logic      done,
	output word_t     rdata,

	output logic      mem_valid,
	input  logic      mem_ready,
	output mem_req_t  mem_req,
	input  logic      mem_rvalid,
	input  word_t     mem_rdata,

	output baddr_t    rbuf_addr,
	input  word_t     rbuf_q,
	output baddr_t    wbuf_addr,
	output word_t     wbuf_data,
	output logic      wbuf_we
);

	typedef enum logic [2:0] {
		XS_IDLE, XS_FETCH, XS_LOAD, XS_REQ, XS_RESP
	} xstate_t;

	xstate_t    state;
	xfer_kind_t kind;
	baddr_t     idx;
	logic [8:0] remaining;
	logic       last;

	assign cmd_ready = (state == XS_IDLE);
	assign mem_valid = (state == XS_REQ);
	assign rbuf_addr = idx;

	// Single-word kinds always finish after one access
	assign last = (kind == XF_RD_WORD) || (kind == XF_WR_WORD) || (remaining == 9'd1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= XS_IDLE;
			done    <= 1'b0;
			wbuf_we <= 1'b0;
		end else begin
			done    <= 1'b0;
			wbuf_we <= 1'b0;
			case (state)
				XS_IDLE:
					if (cmd_valid) begin
						kind          <= cmd.kind;
						idx           <= '0;
						remaining     <= cmd.count;
						mem_req.addr  <= cmd.addr;
						mem_req.wdata <= cmd.wdata;
						mem_req.we    <= (cmd.kind == XF_WR_WORD) ||
						                 (cmd.kind == XF_SECT_TO_MEM);
						state         <= (cmd.kind == XF_SECT_TO_MEM) ? XS_FETCH : XS_REQ;
					end
				// One cycle of buffer read latency
				XS_FETCH:
					state <= XS_LOAD;
				XS_LOAD: begin
					mem_req.wdata <= rbuf_q;
					state         <= XS_REQ;
				end
				XS_REQ:
					if (mem_ready) begin
						if (!mem_req.we) begin
							state <= XS_RESP;
						end else if (last) begin
							done  <= 1'b1;
							state <= XS_IDLE;
						end else begin
							idx          <= idx + 8'd1;
							remaining    <= remaining - 9'd1;
							mem_req.addr <= mem_req.addr + 16'd2;
							state        <= XS_FETCH;
						end
					end
				XS_RESP:
					if (mem_rvalid) begin
						rdata     <= mem_rdata;
						wbuf_data <= mem_rdata;
						wbuf_addr <= idx;
						wbuf_we   <= (kind == XF_MEM_TO_SECT);
						if (last) begin
							done  <= 1'b1;
							state <= XS_IDLE;
						end else begin
							idx          <= idx + 8'd1;
							remaining    <= remaining - 9'd1;
							mem_req.addr <= mem_req.addr + 16'd2;
							state        <= XS_REQ;
						end
					end
				default:
					state <= XS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/sd_link.sv
`timescale 1ns/1ps
`default_nettype none

module sd_link import disk_pkg::*; #(
	parameter int NUM_SLOTS = disk_pkg::NUM_SLOTS,
	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic                 sd_valid,
	output logic                 sd_ready,
	input  logic [SLOT_W-1:0]    slot,
	input  lba_t                 lba,
	input  logic                 sd_we,
	output logic                 sd_done,

	output sd_req_t              sd_req,
	input  logic                 sd_ack,

	input  logic [NUM_SLOTS-1:0] img_mounted,
	input  logic                 img_readonly,
	input  lba_t                 img_size,
	output img_info_t            info
);

	logic                 op_busy;
	logic                 ack_q;
	logic [NUM_SLOTS-1:0] mounted_q;
	logic [2:0]           req_rd;
	logic [2:0]           req_wr;
	lba_t                 req_lba;
	img_info_t            img_tab [NUM_SLOTS];

	assign sd_ready = !op_busy;
	assign sd_req   = '{lba: req_lba, rd: req_rd, wr: req_wr};
	assign info     = img_tab[slot];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			op_busy <= 1'b0;
			ack_q   <= 1'b0;
			sd_done <= 1'b0;
			req_rd  <= '0;
			req_wr  <= '0;
		end else begin
			ack_q   <= sd_ack;
			sd_done <= 1'b0;
			if (sd_valid && sd_ready) begin
				op_busy <= 1'b1;
				// Slot n sits on bit n+1
				if (sd_we) begin
					req_wr <= 3'b010 << slot;
				end else begin
					req_rd <= 3'b010 << slot;
				end
			end
			if (sd_ack && !ack_q) begin
				req_rd <= '0;
				req_wr <= '0;
			end
			if (!sd_ack && ack_q) begin
				op_busy <= 1'b0;
				sd_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sd_valid && sd_ready) begin
			req_lba <= lba;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mounted_q <= '0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				img_tab[i] <= '0;
			end
		end else begin
			mounted_q <= img_mounted;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				if (img_mounted[i] && !mounted_q[i]) begin
					img_tab[i] <= '{size: img_size, readonly: img_readonly};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/disk_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module disk_ctrl import disk_pkg::*; #(
	parameter int NUM_SLOTS = disk_pkg::NUM_SLOTS,
	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              start_valid,
	output logic              start_ready,
	input  gaddr_t            sp,
	output logic              busy,

	output logic              cmd_valid,
	input  logic              cmd_ready,
	output xfer_cmd_t         cmd,
	input  logic              done,
	input  word_t             rdata,

	output logic              sd_valid,
	input  logic              sd_ready,
	input  logic              sd_done,
	output logic [SLOT_W-1:0] slot,
	output lba_t              lba,
	output logic              sd_we,
	input  img_info_t         info
);

	typedef enum logic [4:0] {
		ST_IDLE, ST_PPTR, ST_DISK, ST_BLK, ST_LEN, ST_BUF, ST_PSW, ST_ERR,
		ST_CHECK,
		ST_RD_SD, ST_RD_WAIT, ST_RD_COPY,
		ST_WR_FILL, ST_WR_SD, ST_WR_WAIT,
		ST_POST_ERR, ST_POST_PSW
	} state_t;

	state_t     state;
	logic       issued;

	gaddr_t     sp_q;
	gaddr_t     ppar;
	logic [7:0] disk;
	logic       write;
	word_t      total;
	logic [8:0] part;
	gaddr_t     vaddr;
	word_t      psw;
	word_t      err_word;
	err_code_t  err_code;
	logic       err_flag;

	logic       xfer_state;
	word_t      total_left;
	logic [16:0] total_rnd;
	logic [32:0] end_blk;

	function automatic logic [8:0] part_of(input word_t n);
		return (n > word_t'(SECTOR_WORDS)) ? 9'(SECTOR_WORDS) : n[8:0];
	endfunction

	assign start_ready = (state == ST_IDLE);
	assign busy        = (state != ST_IDLE);
	assign slot        = disk[SLOT_W-1:0];
	assign sd_we       = write;
	assign sd_valid    = (state == ST_RD_SD) || (state == ST_WR_SD);

	assign total_left = total - word_t'(part);
	// Sector count rounded up
	assign total_rnd  = {1'b0, total} + 17'd255;
	assign end_blk    = {1'b0, lba} + 33'(total_rnd[16:8]);

	always_comb begin
		xfer_state = 1'b1;
		cmd        = '{kind: XF_RD_WORD, addr: sp_q, wdata: '0, count: 9'd1};
		case (state)
			ST_PPTR:     cmd.addr = sp_q + 16'd6;
			ST_DISK:     cmd.addr = ppar + 16'o34;
			ST_BLK:      cmd.addr = sp_q;
			ST_LEN:      cmd.addr = sp_q + 16'd2;
			ST_BUF:      cmd.addr = sp_q + 16'd4;
			ST_PSW:      cmd.addr = sp_q + 16'd8;
			ST_ERR:      cmd.addr = ERR_ADDR;
			ST_RD_COPY: begin
				cmd.kind  = XF_SECT_TO_MEM;
				cmd.addr  = vaddr;
				cmd.count = part;
			end
			ST_WR_FILL: begin
				cmd.kind  = XF_MEM_TO_SECT;
				cmd.addr  = vaddr;
				cmd.count = part;
			end
			ST_POST_ERR: begin
				cmd.kind  = XF_WR_WORD;
				cmd.addr  = ERR_ADDR;
				cmd.wdata = {err_word[15:8], err_code};
			end
			ST_POST_PSW: begin
				cmd.kind  = XF_WR_WORD;
				cmd.addr  = sp_q + 16'd8;
				cmd.wdata = {psw[15:1], err_flag};
			end
			default:     xfer_state = 1'b0;
		endcase
	end

	assign cmd_valid = xfer_state && !issued;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			issued <= 1'b0;
		end else if (done) begin
			issued <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			issued <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:
					if (start_valid) begin
						sp_q  <= sp;
						state <= ST_PPTR;
					end
				ST_PPTR:
					if (done) begin
						ppar  <= rdata;
						state <= ST_DISK;
					end
				ST_DISK:
					if (done) begin
						disk  <= rdata[7:0];
						state <= ST_BLK;
					end
				ST_BLK:
					if (done) begin
						lba   <= lba_t'(rdata);
						state <= ST_LEN;
					end
				ST_LEN:
					if (done) begin
						// Negative length requests a write
						write <= rdata[15];
						total <= rdata[15] ? (~rdata + 16'd1) : rdata;
						state <= ST_BUF;
					end
				ST_BUF:
					if (done) begin
						vaddr <= rdata;
						state <= ST_PSW;
					end
				ST_PSW:
					if (done) begin
						psw   <= rdata;
						state <= ST_ERR;
					end
				ST_ERR:
					if (done) begin
						err_word <= rdata;
						state    <= ST_CHECK;
					end
				ST_CHECK: begin
					err_code <= ERR_OK;
					err_flag <= 1'b1;
					state    <= ST_POST_ERR;
					part     <= part_of(total);
					if (disk >= 8'(NUM_SLOTS) || info.size == '0) begin
						err_code <= ERR_BAD_DISK;
					end else if (total == '0 || vaddr[0]) begin
						err_code <= ERR_BAD_ARG;
					end else if (end_blk > {1'b0, info.size}) begin
						err_code <= ERR_RANGE;
					end else if (write && info.readonly) begin
						err_code <= ERR_READONLY;
					end else begin
						err_flag <= 1'b0;
						state    <= write ? ST_WR_FILL : ST_RD_SD;
					end
				end

				ST_RD_SD:
					if (sd_ready) state <= ST_RD_WAIT;
				ST_RD_WAIT:
					if (sd_done) state <= ST_RD_COPY;
				ST_RD_COPY:
					if (done) begin
						vaddr <= vaddr + gaddr_t'({part, 1'b0});
						total <= total_left;
						part  <= part_of(total_left);
						if (total_left != '0) begin
							lba   <= lba + 32'd1;
							state <= ST_RD_SD;
						end else begin
							state <= ST_POST_ERR;
						end
					end

				ST_WR_FILL:
					if (done) state <= ST_WR_SD;
				ST_WR_SD:
					if (sd_ready) state <= ST_WR_WAIT;
				ST_WR_WAIT:
					if (sd_done) begin
						vaddr <= vaddr + gaddr_t'({part, 1'b0});
						total <= total_left;
						part  <= part_of(total_left);
						if (total_left != '0) begin
							lba   <= lba + 32'd1;
							state <= ST_WR_FILL;
						end else begin
							state <= ST_POST_ERR;
						end
					end

				ST_POST_ERR:
					if (done) state <= ST_POST_PSW;
				ST_POST_PSW:
					if (done) state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/disk_top.sv
`timescale 1ns/1ps
`default_nettype none

module disk_top import disk_pkg::*; #(
	parameter int NUM_SLOTS = disk_pkg::NUM_SLOTS
) (
	input  logic                 clk_sys,
	input  logic                 reset,

	input  bus_cycle_t           bus,
	output logic                 bus_ack,
	output logic                 busy,

	output logic                 mem_valid,
	input  logic                 mem_ready,
	output mem_req_t             mem_req,
	input  logic                 mem_rvalid,
	input  word_t                mem_rdata,

	output sd_req_t              sd_req,
	input  logic                 sd_ack,
	input  baddr_t               sd_buff_addr,
	input  word_t                sd_buff_dout,
	output word_t                sd_buff_din,
	input  logic                 sd_buff_wr,

	input  logic [NUM_SLOTS-1:0] img_mounted,
	input  logic                 img_readonly,
	input  lba_t                 img_size
);

	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	logic              start_valid;
	logic              start_ready;
	gaddr_t            sp;

	logic              cmd_valid;
	logic              cmd_ready;
	xfer_cmd_t         cmd;
	logic              done;
	word_t             rdata;

	logic              sd_valid;
	logic              sd_ready;
	logic              sd_done;
	logic [SLOT_W-1:0] slot;
	lba_t              lba;
	logic              sd_we;
	img_info_t         info;

	baddr_t            rbuf_addr;
	word_t             rbuf_q;
	baddr_t            wbuf_addr;
	word_t             wbuf_data;
	logic              wbuf_we;

	bus_regs i_bus_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.start_ready (start_ready),
		.bus_ack     (bus_ack),
		.start_valid (start_valid),
		.sp          (sp)
	);

	disk_ctrl #(.NUM_SLOTS(NUM_SLOTS)) i_disk_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.start_valid (start_valid),
		.sp          (sp),
		.cmd_ready   (cmd_ready),
		.done        (done),
		.rdata       (rdata),
		.sd_ready    (sd_ready),
		.sd_done     (sd_done),
		.info        (info),
		.start_ready (start_ready),
		.busy        (busy),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.sd_valid    (sd_valid),
		.slot        (slot),
		.lba         (lba),
		.sd_we       (sd_we)
	);

	xfer_engine i_xfer_engine (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.mem_ready  (mem_ready),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.rbuf_q     (rbuf_q),
		.cmd_ready  (cmd_ready),
		.done       (done),
		.rdata      (rdata),
		.mem_valid  (mem_valid),
		.mem_req    (mem_req),
		.rbuf_addr  (rbuf_addr),
		.wbuf_addr  (wbuf_addr),
		.wbuf_data  (wbuf_data),
		.wbuf_we    (wbuf_we)
	);

	sd_link #(.NUM_SLOTS(NUM_SLOTS)) i_sd_link (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sd_valid     (sd_valid),
		.slot         (slot),
		.lba          (lba),
		.sd_we        (sd_we),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.sd_ready     (sd_ready),
		.sd_done      (sd_done),
		.sd_req       (sd_req),
		.info         (info)
	);

	// SD host fills this one on reads
	sector_buffer i_rd_buf (
		.clk_sys (clk_sys),
		.waddr   (sd_buff_addr),
		.wdata   (sd_buff_dout),
		.we      (sd_buff_wr),
		.raddr   (rbuf_addr),
		.q       (rbuf_q)
	);

	// SD host drains this one on writes
	sector_buffer i_wr_buf (
		.clk_sys (clk_sys),
		.waddr   (wbuf_addr),
		.wdata   (wbuf_data),
		.we      (wbuf_we),
		.raddr   (sd_buff_addr),
		.q       (sd_buff_din)
	);

endmodule

`default_nettype wire

//--- test/disk_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module disk_assertions import disk_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input logic     busy,
	input logic     mem_valid,
	input logic     mem_ready,
	input mem_req_t mem_req,
	input sd_req_t  sd_req
);

	// Held request must not move until accepted
	assert property (@(posedge clk_sys) disable iff (reset)
		mem_valid && !mem_ready |=> $stable(mem_req))
		else $error("mem_req changed while stalled");

	assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({sd_req.rd, sd_req.wr}))
		else $error("more than one sd_req bit set");

	assert property (@(posedge clk_sys)
		$past(reset) |-> !busy && !mem_valid && sd_req.rd == '0 && sd_req.wr == '0)
		else $error("outputs active after reset");

endmodule

bind disk_top disk_assertions i_disk_assertions (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.busy      (busy),
	.mem_valid (mem_valid),
	.mem_ready (mem_ready),
	.mem_req   (mem_req),
	.sd_req    (sd_req)
);

`default_nettype wire

//--- test/disk_tb.sv
`timescale 1ns/1ps
`default_nettype none

module disk_tb import disk_pkg::*;;

	localparam int IMG_WORDS = 16384;
	localparam gaddr_t SP_BASE = 16'h0200;
	localparam gaddr_t PPAR = 16'h0300;

	logic clk_sys = 1'b0;
	logic reset = 1'b1;
	bus_cycle_t bus = '0;
	logic bus_ack;
	logic busy;
	logic mem_valid;
	logic mem_ready = 1'b0;
	mem_req_t mem_req;
	logic mem_rvalid = 1'b0;
	word_t mem_rdata = '0;
	sd_req_t sd_req;
	logic sd_ack = 1'b0;
	baddr_t sd_buff_addr = '0;
	word_t sd_buff_dout = '0;
	word_t sd_buff_din;
	logic sd_buff_wr = 1'b0;
	logic [1:0] img_mounted = '0;
	logic img_readonly = 1'b0;
	lba_t img_size = '0;

	word_t mem [0:32767];
	word_t img [0:1][0:IMG_WORDS-1];
	logic [31:0] rng = 32'h0b3e8d5f;
	int stall = 0;
	int sd_ops = 0;
	int checks = 0;
	int errors = 0;
	logic aborted = 1'b0;

	always #5 clk_sys = ~clk_sys;

	disk_top #(.NUM_SLOTS(2)) i_disk_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.bus_ack      (bus_ack),
		.busy         (busy),
		.mem_valid    (mem_valid),
		.mem_ready    (mem_ready),
		.mem_req      (mem_req),
		.mem_rvalid   (mem_rvalid),
		.mem_rdata    (mem_rdata),
		.sd_req       (sd_req),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din),
		.sd_buff_wr   (sd_buff_wr),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t guest_fill(input gaddr_t a);
		return (a * 16'd5) ^ 16'h3c3c;
	endfunction

	function automatic word_t image_word(input int s, input int i);
		return word_t'(i * 7) + (s != 0 ? 16'h8000 : 16'h0000) + 16'h1111;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// Guest memory with random ready stalls
	always @(posedge clk_sys) begin
		mem_rvalid <= 1'b0;
		if (reset) begin
			mem_ready <= 1'b0;
			stall <= 0;
		end else if (mem_valid && mem_ready) begin
			mem_ready <= 1'b0;
			if (mem_req.we) begin
				mem[mem_req.addr[15:1]] = mem_req.wdata;
			end else begin
				mem_rdata <= mem[mem_req.addr[15:1]];
				mem_rvalid <= 1'b1;
			end
		end else if (mem_valid) begin
			if (stall == 0) begin
				mem_ready <= 1'b1;
				rng = lcg_next(rng);
				stall <= int'(rng[17:16]);
			end else begin
				stall <= stall - 1;
			end
		end
	end

	task automatic serve_sd();
		int s;
		int base;
		logic wr;
		s = (sd_req.rd[2] || sd_req.wr[2]) ? 1 : 0;
		wr = |sd_req.wr;
		base = int'(sd_req.lba) * SECTOR_WORDS;
		sd_ops++;
		sd_ack <= 1'b1;
		if (!wr) begin
			for (int j = 0; j < SECTOR_WORDS; j++) begin
				@(posedge clk_sys);
				sd_buff_addr <= baddr_t'(j);
				sd_buff_dout <= (base + j < IMG_WORDS) ? img[s][base + j] : 16'h0000;
				sd_buff_wr <= 1'b1;
			end
		end else begin
			// Buffer read data trails the address by two edges
			for (int j = 0; j < SECTOR_WORDS + 2; j++) begin
				@(posedge clk_sys);
				if (j >= 2 && base + j - 2 < IMG_WORDS) begin
					img[s][base + j - 2] = sd_buff_din;
				end
				sd_buff_addr <= baddr_t'(j);
			end
		end
		@(posedge clk_sys);
		sd_buff_wr <= 1'b0;
		sd_ack <= 1'b0;
	endtask

	always begin
		@(posedge clk_sys);
		if (!reset && !sd_ack && (|sd_req.rd[2:1] || |sd_req.wr[2:1])) begin
			serve_sd();
		end
	end

	task automatic wait_busy(input logic level, input int limit, input string what,
	                         output logic ok);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		ok = (busy === level);
		if (!ok) begin
			errors++;
			$display("timeout waiting for %s", what);
		end
	endtask

	task automatic mount_slot(input int s, input lba_t size, input logic ro);
		@(posedge clk_sys);
		img_size <= size;
		img_readonly <= ro;
		img_mounted <= 2'(1 << s);
		@(posedge clk_sys);
		img_mounted <= '0;
		@(posedge clk_sys);
	endtask

	task automatic pulse_bus(input gaddr_t addr, input word_t din, input logic we,
	                         input logic exp_ack);
		@(posedge clk_sys);
		bus <= '{addr: addr, din: din, sync: 1'b1, we: we, stb: 1'b1};
		@(negedge clk_sys);
		check_value("bus_ack", 32'(bus_ack), 32'(exp_ack));
		@(posedge clk_sys);
		bus <= '0;
	endtask

	task automatic run_request(input int num, input logic [7:0] disk, input lba_t lba,
	                           input word_t len, input gaddr_t buf_addr,
	                           input err_code_t exp);
		logic wr;
		logic ok;
		int n;
		int s;
		int ops0;
		int exp_ops;
		word_t psw;
		wr = len[15];
		n = wr ? int'(16'(-len)) : int'(len);
		s = int'(disk[0]);
		psw = 16'h0a50 | 16'(num & 1);
		mem[SP_BASE[15:1]] = lba[15:0];
		mem[SP_BASE[15:1] + 1] = len;
		mem[SP_BASE[15:1] + 2] = buf_addr;
		mem[SP_BASE[15:1] + 3] = PPAR;
		mem[SP_BASE[15:1] + 4] = psw;
		mem[(PPAR + 16'o34) >> 1] = {8'h00, disk};
		mem[ERR_ADDR[15:1]] = 16'hc3ff;
		for (int i = 0; i <= n; i++) begin
			mem[buf_addr[15:1] + i] = guest_fill({buf_addr[15:1], 1'b0} + 16'(2 * i));
		end
		ops0 = sd_ops;
		pulse_bus(REG_LBA, SP_BASE, 1'b1, 1'b1);
		wait_busy(1'b1, 20, "busy to rise", ok);
		if (ok) begin
			wait_busy(1'b0, 200000, "busy to fall", ok);
		end

		if (!ok) begin
			aborted = 1'b1;
		end else begin
			check_value("err_word", 32'(mem[ERR_ADDR[15:1]]), {16'h0, 8'hc3, exp});
			check_value("psw", 32'(mem[SP_BASE[15:1] + 4]),
			            {16'h0, psw[15:1], exp != ERR_OK});
			exp_ops = (exp == ERR_OK) ? (n + SECTOR_WORDS - 1) / SECTOR_WORDS : 0;
			check_value("sd_ops", 32'(sd_ops - ops0), 32'(exp_ops));
			if (exp == ERR_OK && !wr) begin
				for (int i = 0; i < n; i++) begin
					check_value("read_word", 32'(mem[buf_addr[15:1] + i]),
					            32'(img[s][int'(lba) * SECTOR_WORDS + i]));
				end
			end else if (exp == ERR_OK) begin
				for (int i = 0; i < n; i++) begin
					check_value("image_word", 32'(img[s][int'(lba) * SECTOR_WORDS + i]),
					            32'(guest_fill(buf_addr + 16'(2 * i))));
				end
			end
			// Word past the buffer must survive
			check_value("guard_word", 32'(mem[buf_addr[15:1] + n]),
			            32'(guest_fill({buf_addr[15:1], 1'b0} + 16'(2 * n))));
		end
	endtask

	initial begin
		int fd;
		int cnt;
		int num;
		string line;
		logic [31:0] size0, ro0, size1, ro1, disk, lba, len, buf_addr, exp;
		for (int i = 0; i < 32768; i++) begin
			mem[i] = guest_fill(16'(2 * i));
		end
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < IMG_WORDS; i++) begin
				img[s][i] = image_word(s, i);
			end
		end
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("busy", 32'(busy), 32'h0);

		// Reads and other addresses are not acked
		pulse_bus(REG_LBA, SP_BASE, 1'b0, 1'b0);
		pulse_bus(16'o177130, SP_BASE, 1'b1, 1'b0);
		repeat (3) @(negedge clk_sys);
		check_value("busy", 32'(busy), 32'h0);

		fd = $fopen("test/disk_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open test/disk_input.txt");
		end else begin
			num = 0;
			while (!aborted && !$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
				              size0, ro0, size1, ro1, disk, lba, len, buf_addr, exp);
				if (cnt != 9) begin
					continue;
				end
				mount_slot(0, size0, ro0[0]);
				mount_slot(1, size1, ro1[0]);
				run_request(num, disk[7:0], lba, len[15:0], buf_addr[15:0], exp[7:0]);
				num++;
			end
			$fclose(fd);
			if (!aborted) begin
				check_value("requests", 32'(num), 32'd15);
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/disk_input.txt
# size0 ro0 size1 ro1 disk lba len buf expected_code (all hex, sizes in blocks)
# negative len is a write of its magnitude in words
40 0 20 0 0 5 030A 4000 00
40 0 20 0 1 3 FED4 5000 00
40 0 20 0 1 3 012C 6000 00
40 0 20 0 2 0 0010 4000 06
40 0 0 0 1 0 0010 4000 06
40 0 20 0 0 0 0000 4000 0A
40 0 20 0 0 0 0010 4001 0A
40 0 20 0 0 3F 0101 4000 05
40 0 20 1 1 0 FF00 4000 01
40 0 20 0 0 0 0100 7000 00
40 0 20 0 0 3F 0001 7800 00
40 1 20 0 0 2 0020 7800 00
40 0 20 0 2 0 0000 4001 06
40 0 20 0 0 3F 0200 4001 0A
40 1 20 0 0 3F FE00 4000 05

//--- flist.f
src/disk_pkg.sv
src/sector_buffer.sv
src/bus_regs.sv
src/xfer_engine.sv
src/sd_link.sv
src/disk_ctrl.sv
src/disk_top.sv
test/disk_assertions.sv
test/disk_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module disk_tb -f flist.f \
	-o disk_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/disk_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0
